//--- s2mm_rx_defines.svh
/*
 * s2mm receive path constants
 * beat and keep widths, fifo depths, the almost-full margin
 * and the number of control words emitted per good frame
 */
`ifndef S2MM_RX_DEFINES_SVH
`define S2MM_RX_DEFINES_SVH

// beat format
`define S2MM_DATA_W        64
`define S2MM_KEEP_W        8

// fifo depths
`define S2MM_DATA_DEPTH    64
`define S2MM_INFO_DEPTH    8
`define S2MM_GOOD_DEPTH    64
`define S2MM_CTRL_DEPTH    32

// free entries at or below which almost-full rises
`define S2MM_AFULL_MARGIN  8

// control words per good frame
`define S2MM_CTRL_WORDS    6

`endif

//--- s2mm_frame_pkg.sv
/*
 * s2mm frame types
 * one stored beat of the data path and the per-frame info word
 * that the ingress stage writes after the last beat
 */
`include "s2mm_rx_defines.svh"

package s2mm_frame_pkg;

   // stored beat, last in the msb as in the 73 bit fifo word
   typedef struct packed
   {
      logic                    last;
      logic [`S2MM_KEEP_W-1:0] keep;
      logic [`S2MM_DATA_W-1:0] data;
   } beat_t;

   // one entry per frame
   // drop set when rx_bad came with the last beat
   typedef struct packed
   {
      logic        drop;
      logic        tag;
      // ones' complement sum over all masked lanes
      logic [15:0] sum;
   } info_t;

endpackage

//--- s2mm_ctrl_pkg.sv
/*
 * s2mm control stream types
 * the control fifo word and the index naming the six words
 * of the per-frame control record
 */
`include "s2mm_rx_defines.svh"

package s2mm_ctrl_pkg;

   // 32 bit data, 4 keep bits, last on the final word
   typedef struct packed
   {
      logic        last;
      logic [3:0]  keep;
      logic [31:0] data;
   } ctrl_word_t;

   localparam int CTRL_IDX_W = $clog2(`S2MM_CTRL_WORDS);

   // word order within one control record
   typedef enum logic [CTRL_IDX_W-1:0]
   {
      ctrl_flags     = 3'd0,
      ctrl_addr_hi   = 3'd1,
      ctrl_addr_lo   = 3'd2,
      ctrl_tag_flags = 3'd3,
      ctrl_csum      = 3'd4,
      ctrl_bytecnt   = 3'd5
   } ctrl_idx_t;

endpackage

//--- sync_fifo.sv
/*
 * synchronous fifo, first word fall through
 * head entry is presented while empty is low, rden pops it
 * almost-full is registered from the occupancy count
 */
module sync_fifo #(
   parameter type payload_t    = logic,
   parameter int  DEPTH        = 16,
   parameter int  AFULL_MARGIN = 4
) (
   input  logic     s2mm_clk,
   input  logic     sys_rst,
   input  logic     wren,
   input  payload_t wdata,
   input  logic     rden,
   output payload_t rdata,
   output logic     empty,
   output logic     afull
);

   localparam int AW = $clog2(DEPTH);
   localparam int CW = $clog2(DEPTH + 1);

   payload_t        mem [DEPTH];
   logic [AW-1:0]   wr_ptr;
   logic [AW-1:0]   rd_ptr;
   logic [CW-1:0]   count;
   logic [CW-1:0]   count_nxt;
   logic            wr_ok;
   logic            rd_ok;

   // overflow and underflow attempts are dropped
   assign wr_ok = wren && (count != CW'(DEPTH));
   assign rd_ok = rden && (count != '0);

   always_comb
   begin
      count_nxt = count;
      if (wr_ok && !rd_ok)
         count_nxt = count + 1'b1;
      else if (rd_ok && !wr_ok)
         count_nxt = count - 1'b1;
   end

   always_ff @(posedge s2mm_clk or posedge sys_rst)
   begin
      if (sys_rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         afull  <= 1'b0;
      end
      else
      begin
         if (wr_ok)
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (rd_ok)
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         count <= count_nxt;
         // tracks the count that is about to be stored
         afull <= (DEPTH - int'(count_nxt)) <= AFULL_MARGIN;
      end
   end

   // storage, no reset
   always_ff @(posedge s2mm_clk)
   begin
      if (wr_ok)
         mem[wr_ptr] <= wdata;
   end

   assign rdata = mem[rd_ptr];
   assign empty = (count == '0);

endmodule

//--- rx_ingress.sv
/*
 * receive ingress stage
 * writes every accepted beat to the data fifo, sums the masked
 * 16 bit lanes with end-around carry, and after the last beat
 * writes the drop flag, tag and checksum to the info fifo
 */
`include "s2mm_rx_defines.svh"

module rx_ingress (
   input  logic                      s2mm_clk,
   input  logic                      sys_rst,
   input  logic                      rx_valid,
   input  logic [`S2MM_DATA_W-1:0]   rx_data,
   input  logic [`S2MM_KEEP_W-1:0]   rx_keep,
   input  logic                      rx_last,
   input  logic                      rx_bad,
   input  logic                      rx_tag,
   input  logic                      data_afull,
   input  logic                      info_afull,
   output logic                      rx_full,
   output logic                      data_wren,
   output s2mm_frame_pkg::beat_t     data_wdata,
   output logic                      info_wren,
   output s2mm_frame_pkg::info_t     info_wdata
);

   localparam int LANES = `S2MM_DATA_W / 16;

   logic [`S2MM_DATA_W-1:0] masked;
   logic [15:0]             csum_acc;
   logic [18:0]             raw_sum;
   logic [16:0]             fold_sum;
   logic [15:0]             csum_nxt;

   // source holds off on either fifo nearing full
   assign rx_full = data_afull | info_afull;

   // beat goes straight into the data fifo
   assign data_wren       = rx_valid;
   assign data_wdata.last = rx_last;
   assign data_wdata.keep = rx_keep;
   assign data_wdata.data = rx_data;

   // zero bytes outside keep
   always_comb
   begin
      for (int i = 0; i < `S2MM_KEEP_W; i++)
         masked[8*i +: 8] = rx_keep[i] ? rx_data[8*i +: 8] : 8'h00;
   end

   // running sum plus four lanes, then fold carries back in twice
   always_comb
   begin
      raw_sum = {3'b000, csum_acc};
      for (int i = 0; i < LANES; i++)
         raw_sum = raw_sum + {3'b000, masked[16*i +: 16]};
      fold_sum = {1'b0, raw_sum[15:0]} + {14'h0, raw_sum[18:16]};
      csum_nxt = fold_sum[15:0] + {15'h0, fold_sum[16]};
   end

   always_ff @(posedge s2mm_clk or posedge sys_rst)
   begin
      if (sys_rst)
      begin
         csum_acc  <= '0;
         info_wren <= 1'b0;
      end
      else
      begin
         // info write trails the last beat by one cycle
         info_wren <= rx_valid && rx_last;
         if (rx_valid)
            csum_acc <= rx_last ? 16'h0 : csum_nxt;
      end
   end

   // info payload captured with the last beat
   always_ff @(posedge s2mm_clk)
   begin
      if (rx_valid && rx_last)
      begin
         info_wdata.drop <= rx_bad;
         info_wdata.tag  <= rx_tag;
         info_wdata.sum  <= csum_nxt;
      end
   end

endmodule

//--- ifm_out_fsm.sv
/*
 * output state machine
 * per frame from the info fifo, either copies the beats into the
 * good fifo and then writes six control words, or reads the beats
 * out and discards them when the drop flag is set
 */
`include "s2mm_rx_defines.svh"

module ifm_out_fsm (
   input  logic                        s2mm_clk,
   input  logic                        sys_rst,
   input  s2mm_frame_pkg::beat_t       data_rdata,
   output logic                        data_rden,
   input  s2mm_frame_pkg::info_t       info_rdata,
   input  logic                        info_empty,
   output logic                        info_rden,
   output s2mm_frame_pkg::beat_t       good_wdata,
   output logic                        good_wren,
   input  logic                        good_afull,
   output s2mm_ctrl_pkg::ctrl_word_t   ctrl_wdata,
   output logic                        ctrl_wren,
   input  logic                        ctrl_afull
);

   typedef enum logic [2:0]
   {
      st_idle,
      st_copy,
      st_drop,
      st_ctrl,
      st_done
   } state_t;

   state_t                    state;
   state_t                    state_nxt;
   logic                      ready_sof;
   s2mm_frame_pkg::info_t     info_reg;
   s2mm_ctrl_pkg::ctrl_idx_t  wcnt;
   logic [3:0]                keep_cnt;
   logic [3:0]                good_bytes;
   logic [15:0]               bytecnt;
   logic [31:0]               ctrl_data;

   // info entry means the whole frame is already in the data fifo
   assign ready_sof = !info_empty && !good_afull && !ctrl_afull;

   always_comb
   begin
      state_nxt = state;
      case (state)
         st_idle:
            if (ready_sof)
               state_nxt = info_rdata.drop ? st_drop : st_copy;
         st_copy:
            if (data_rdata.last)
               state_nxt = st_ctrl;
         st_drop:
            if (data_rdata.last)
               state_nxt = st_done;
         st_ctrl:
            if (wcnt == s2mm_ctrl_pkg::ctrl_idx_t'(`S2MM_CTRL_WORDS - 1))
               state_nxt = st_done;
         default:
            state_nxt = st_idle;
      endcase
   end

   // info popped as the frame is started
   assign info_rden = (state == st_idle) && ready_sof;
   assign data_rden = (state == st_copy) || (state == st_drop);

   // bytes in the head beat
   always_comb
   begin
      keep_cnt = 4'h0;
      for (int i = 0; i < `S2MM_KEEP_W; i++)
         keep_cnt = keep_cnt + {3'b000, data_rdata.keep[i]};
   end

   always_ff @(posedge s2mm_clk or posedge sys_rst)
   begin
      if (sys_rst)
      begin
         state     <= st_idle;
         good_wren <= 1'b0;
         ctrl_wren <= 1'b0;
         wcnt      <= s2mm_ctrl_pkg::ctrl_flags;
         bytecnt   <= 16'h0;
      end
      else
      begin
         state     <= state_nxt;
         good_wren <= (state == st_copy);
         ctrl_wren <= (state == st_ctrl);
         if (state == st_idle)
            wcnt <= s2mm_ctrl_pkg::ctrl_flags;
         else if (state == st_ctrl)
            wcnt <= s2mm_ctrl_pkg::ctrl_idx_t'(wcnt + 1'b1);
         // count lags the good write by nothing, keep count rides along
         if (state == st_idle)
            bytecnt <= 16'h0;
         else if (good_wren)
            bytecnt <= bytecnt + {12'h0, good_bytes};
      end
   end

   // payload registers
   always_ff @(posedge s2mm_clk)
   begin
      if (state == st_idle)
         info_reg <= info_rdata;
      good_wdata <= data_rdata;
      good_bytes <= keep_cnt;
   end

   // control record contents by word index
   always_comb
   begin
      ctrl_data = 32'h0;
      case (wcnt)
         s2mm_ctrl_pkg::ctrl_flags:
            ctrl_data[31:28] = 4'h5;
         s2mm_ctrl_pkg::ctrl_tag_flags:
         begin
            ctrl_data[7] = ~info_reg.tag;
            ctrl_data[6] = info_reg.tag;
         end
         s2mm_ctrl_pkg::ctrl_csum:
            ctrl_data[15:0] = info_reg.sum;
         s2mm_ctrl_pkg::ctrl_bytecnt:
            ctrl_data[15:0] = bytecnt;
         // multicast address words stay zero
         default:
            ctrl_data = 32'h0;
      endcase
   end

   always_ff @(posedge s2mm_clk)
   begin
      ctrl_wdata.last <= (wcnt == s2mm_ctrl_pkg::ctrl_bytecnt);
      ctrl_wdata.keep <= 4'hf;
      ctrl_wdata.data <= ctrl_data;
   end

endmodule

//--- s2mm_rx_top.sv
/*
 * s2mm receive path top
 * ingress stage, data and info fifos, output state machine,
 * and the good and control fifos read from outside
 */
`include "s2mm_rx_defines.svh"

module s2mm_rx_top (
   input  logic                        s2mm_clk,
   input  logic                        sys_rst,
   input  logic                        rx_valid,
   input  logic [`S2MM_DATA_W-1:0]     rx_data,
   input  logic [`S2MM_KEEP_W-1:0]     rx_keep,
   input  logic                        rx_last,
   input  logic                        rx_bad,
   input  logic                        rx_tag,
   output logic                        rx_full,
   input  logic                        good_rd,
   output s2mm_frame_pkg::beat_t       good_rdata,
   output logic                        good_empty,
   input  logic                        ctrl_rd,
   output s2mm_ctrl_pkg::ctrl_word_t   ctrl_rdata,
   output logic                        ctrl_empty
);

   logic                        data_wren;
   s2mm_frame_pkg::beat_t       data_wdata;
   logic                        data_rden;
   s2mm_frame_pkg::beat_t       data_rdata;
   // only watched by the bound checker
   logic                        data_empty;
   logic                        data_afull;
   logic                        info_wren;
   s2mm_frame_pkg::info_t       info_wdata;
   logic                        info_rden;
   s2mm_frame_pkg::info_t       info_rdata;
   logic                        info_empty;
   logic                        info_afull;
   logic                        good_wren;
   s2mm_frame_pkg::beat_t       good_wdata;
   logic                        good_afull;
   logic                        ctrl_wren;
   s2mm_ctrl_pkg::ctrl_word_t   ctrl_wdata;
   logic                        ctrl_afull;

   rx_ingress u_rx_ingress (
      .s2mm_clk   (s2mm_clk),
      .sys_rst    (sys_rst),
      .rx_valid   (rx_valid),
      .rx_data    (rx_data),
      .rx_keep    (rx_keep),
      .rx_last    (rx_last),
      .rx_bad     (rx_bad),
      .rx_tag     (rx_tag),
      .data_afull (data_afull),
      .info_afull (info_afull),
      .rx_full    (rx_full),
      .data_wren  (data_wren),
      .data_wdata (data_wdata),
      .info_wren  (info_wren),
      .info_wdata (info_wdata)
   );

   sync_fifo #(
      .payload_t    (s2mm_frame_pkg::beat_t),
      .DEPTH        (`S2MM_DATA_DEPTH),
      .AFULL_MARGIN (`S2MM_AFULL_MARGIN)
   ) u_data_fifo (
      .s2mm_clk (s2mm_clk), .sys_rst (sys_rst),
      .wren     (data_wren), .wdata (data_wdata),
      .rden     (data_rden), .rdata (data_rdata),
      .empty    (data_empty), .afull (data_afull)
   );

   // shallow info fifo, margin scaled to its depth
   sync_fifo #(
      .payload_t    (s2mm_frame_pkg::info_t),
      .DEPTH        (`S2MM_INFO_DEPTH),
      .AFULL_MARGIN (`S2MM_INFO_DEPTH / 2)
   ) u_info_fifo (
      .s2mm_clk (s2mm_clk), .sys_rst (sys_rst),
      .wren     (info_wren), .wdata (info_wdata),
      .rden     (info_rden), .rdata (info_rdata),
      .empty    (info_empty), .afull (info_afull)
   );

   ifm_out_fsm u_ifm_out_fsm (
      .s2mm_clk   (s2mm_clk),
      .sys_rst    (sys_rst),
      .data_rdata (data_rdata),
      .data_rden  (data_rden),
      .info_rdata (info_rdata),
      .info_empty (info_empty),
      .info_rden  (info_rden),
      .good_wdata (good_wdata),
      .good_wren  (good_wren),
      .good_afull (good_afull),
      .ctrl_wdata (ctrl_wdata),
      .ctrl_wren  (ctrl_wren),
      .ctrl_afull (ctrl_afull)
   );

   sync_fifo #(
      .payload_t    (s2mm_frame_pkg::beat_t),
      .DEPTH        (`S2MM_GOOD_DEPTH),
      .AFULL_MARGIN (`S2MM_AFULL_MARGIN)
   ) u_good_fifo (
      .s2mm_clk (s2mm_clk), .sys_rst (sys_rst),
      .wren     (good_wren), .wdata (good_wdata),
      .rden     (good_rd), .rdata (good_rdata),
      .empty    (good_empty), .afull (good_afull)
   );

   sync_fifo #(
      .payload_t    (s2mm_ctrl_pkg::ctrl_word_t),
      .DEPTH        (`S2MM_CTRL_DEPTH),
      .AFULL_MARGIN (`S2MM_AFULL_MARGIN)
   ) u_ctrl_fifo (
      .s2mm_clk (s2mm_clk), .sys_rst (sys_rst),
      .wren     (ctrl_wren), .wdata (ctrl_wdata),
      .rden     (ctrl_rd), .rdata (ctrl_rdata),
      .empty    (ctrl_empty), .afull (ctrl_afull)
   );

endmodule

//--- s2mm_rx_sva.sv
/*
 * output state machine checker
 * data fifo never read while empty, control writes in runs of six,
 * good and control writes never in the same cycle
 */
module s2mm_rx_sva (
   input logic s2mm_clk,
   input logic sys_rst,
   input logic data_rden,
   input logic data_empty,
   input logic good_wren,
   input logic ctrl_wren
);

   timeunit 1ns;
   timeprecision 100ps;

   // length of the current control write run
   logic [3:0] ctrl_run;

   always_ff @(posedge s2mm_clk or posedge sys_rst)
   begin
      if (sys_rst)
         ctrl_run <= 4'd0;
      else if (ctrl_wren)
         ctrl_run <= ctrl_run + 4'd1;
      else
         ctrl_run <= 4'd0;
   end

   a_no_underrun : assert property (@(posedge s2mm_clk) disable iff (sys_rst)
      !(data_rden && data_empty))
      else $error("data fifo read while empty");

   // no seventh word inside a run
   a_ctrl_max : assert property (@(posedge s2mm_clk) disable iff (sys_rst)
      ctrl_wren |-> (ctrl_run < 4'd6))
      else $error("control write run longer than six");

   // a run ends only after the sixth word
   a_ctrl_end : assert property (@(posedge s2mm_clk) disable iff (sys_rst)
      $fell(ctrl_wren) |-> (ctrl_run == 4'd6))
      else $error("control write run shorter than six");

   a_one_writer : assert property (@(posedge s2mm_clk) disable iff (sys_rst)
      !(good_wren && ctrl_wren))
      else $error("good and control writes in the same cycle");

endmodule

// watches the state machine strobes where the data fifo flag is visible
bind s2mm_rx_top s2mm_rx_sva u_s2mm_rx_sva (
   .s2mm_clk   (s2mm_clk),
   .sys_rst    (sys_rst),
   .data_rden  (data_rden),
   .data_empty (data_empty),
   .good_wren  (good_wren),
   .ctrl_wren  (ctrl_wren)
);

//--- s2mm_rx_tb.sv
/*
 * testbench for the s2mm receive path
 * sends frames into the ingress port, models the good beats and
 * the six word control record of each frame, and drains both outputs
 */
`include "s2mm_rx_defines.svh"

module s2mm_rx_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD  = 100;
   localparam int DRIVE_DELAY = 1;
   // longest any single wait may last, in cycles
   localparam int WAIT_LIMIT  = 2000;

   logic                        s2mm_clk;
   logic                        sys_rst;
   logic                        rx_valid;
   logic [`S2MM_DATA_W-1:0]     rx_data;
   logic [`S2MM_KEEP_W-1:0]     rx_keep;
   logic                        rx_last;
   logic                        rx_bad;
   logic                        rx_tag;
   logic                        rx_full;
   logic                        good_rd;
   s2mm_frame_pkg::beat_t       good_rdata;
   logic                        good_empty;
   logic                        ctrl_rd;
   s2mm_ctrl_pkg::ctrl_word_t   ctrl_rdata;
   logic                        ctrl_empty;

   // expected output streams
   s2mm_frame_pkg::beat_t       exp_good [$];
   s2mm_ctrl_pkg::ctrl_word_t   exp_ctrl [$];

   int errors;
   int checks;
   int seed;
   int last_seen;
   int good_frames;
   bit sending_done;
   bit timed_out;

   s2mm_rx_top u_s2mm_rx_top (
      .s2mm_clk   (s2mm_clk),
      .sys_rst    (sys_rst),
      .rx_valid   (rx_valid),
      .rx_data    (rx_data),
      .rx_keep    (rx_keep),
      .rx_last    (rx_last),
      .rx_bad     (rx_bad),
      .rx_tag     (rx_tag),
      .rx_full    (rx_full),
      .good_rd    (good_rd),
      .good_rdata (good_rdata),
      .good_empty (good_empty),
      .ctrl_rd    (ctrl_rd),
      .ctrl_rdata (ctrl_rdata),
      .ctrl_empty (ctrl_empty)
   );

   initial
   begin
      s2mm_clk = 1'b0;
      forever
         #(CLK_PERIOD / 2) s2mm_clk = ~s2mm_clk;
   end

   // every task starts and ends just after a rising edge
   task automatic step();
      @(posedge s2mm_clk);
      #DRIVE_DELAY;
   endtask

   task automatic report_timeout(input string what);
      errors++;
      timed_out = 1'b1;
      $display("timeout at %0t while waiting for %s", $time, what);
   endtask

   // contiguous keep from bit 0
   function automatic logic [7:0] keep_of(input int nbytes);
      logic [7:0] k;
      k = 8'h00;
      for (int i = 0; i < nbytes; i++)
         k[i] = 1'b1;
      return k;
   endfunction

   // plain sum of the four masked 16 bit lanes
   function automatic longint lane_total(input logic [63:0] data, input logic [7:0] keep);
      logic [63:0] m;
      longint      t;
      t = 0;
      for (int i = 0; i < 8; i++)
         m[8*i +: 8] = keep[i] ? data[8*i +: 8] : 8'h00;
      for (int i = 0; i < 4; i++)
         t = t + longint'(m[16*i +: 16]);
      return t;
   endfunction

   // end-around carry until 16 bits remain
   function automatic logic [15:0] fold16(input longint total);
      longint v;
      v = total;
      while (v > 64'hffff)
         v = (v & 64'hffff) + (v >> 16);
      return v[15:0];
   endfunction

   function automatic s2mm_ctrl_pkg::ctrl_word_t ctrl_word(input bit last,
                                                           input logic [31:0] data);
      s2mm_ctrl_pkg::ctrl_word_t w;
      w.last = last;
      w.keep = 4'hf;
      w.data = data;
      return w;
   endfunction

   task automatic send_frame(input int nbeats, input int last_bytes, input bit bad,
                             input bit tag);
      s2mm_frame_pkg::beat_t beat;
      longint                total;
      int                    bytes;
      int                    waited;
      total = 0;
      bytes = 0;
      for (int b = 0; b < nbeats; b++)
      begin
         beat.last = (b == nbeats - 1);
         beat.keep = beat.last ? keep_of(last_bytes) : 8'hff;
         beat.data = {$random(seed), $random(seed)};
         total = total + lane_total(beat.data, beat.keep);
         bytes = bytes + $countones(beat.keep);
         if (!bad)
            exp_good.push_back(beat);
         // source holds off while rx_full is up
         waited = 0;
         rx_valid = 1'b0;
         while (rx_full && waited < WAIT_LIMIT && !timed_out)
         begin
            step();
            waited++;
         end
         if (rx_full && !timed_out)
            report_timeout("rx_full to fall");
         rx_valid = 1'b1;
         rx_data  = beat.data;
         rx_keep  = beat.keep;
         rx_last  = beat.last;
         rx_bad   = bad;
         rx_tag   = tag;
         step();
      end
      rx_valid = 1'b0;
      rx_last  = 1'b0;
      // control record of a good frame
      if (!bad)
      begin
         exp_ctrl.push_back(ctrl_word(1'b0, 32'h5000_0000));
         exp_ctrl.push_back(ctrl_word(1'b0, 32'h0));
         exp_ctrl.push_back(ctrl_word(1'b0, 32'h0));
         exp_ctrl.push_back(ctrl_word(1'b0, tag ? 32'h40 : 32'h80));
         exp_ctrl.push_back(ctrl_word(1'b0, {16'h0, fold16(total)}));
         exp_ctrl.push_back(ctrl_word(1'b1, 32'(bytes)));
         good_frames++;
      end
   endtask

   task automatic compare_beat();
      s2mm_frame_pkg::beat_t want;
      checks++;
      assert (exp_good.size() > 0)
      else
      begin
         errors++;
         $display("Fail at %0t: unexpected good beat %h", $time, good_rdata);
      end
      if (exp_good.size() > 0)
      begin
         want = exp_good.pop_front();
         assert (good_rdata == want)
         else
         begin
            errors++;
            $display("Fail at %0t: good beat %h, expected %h", $time, good_rdata, want);
         end
      end
   endtask

   task automatic compare_ctrl();
      s2mm_ctrl_pkg::ctrl_word_t want;
      checks++;
      if (ctrl_rdata.last)
         last_seen++;
      assert (exp_ctrl.size() > 0)
      else
      begin
         errors++;
         $display("Fail at %0t: unexpected control word %h", $time, ctrl_rdata);
      end
      if (exp_ctrl.size() > 0)
      begin
         want = exp_ctrl.pop_front();
         assert (ctrl_rdata == want)
         else
         begin
            errors++;
            $display("Fail at %0t: control word %h, expected %h", $time, ctrl_rdata, want);
         end
      end
   endtask

   // reads both outputs until every expected word is seen
   task automatic drain_outputs();
      int idle;
      idle = 0;
      while (!(sending_done && exp_good.size() == 0 && exp_ctrl.size() == 0)
             && !timed_out)
      begin
         good_rd = !good_empty;
         ctrl_rd = !ctrl_empty;
         if (!good_empty)
            compare_beat();
         if (!ctrl_empty)
            compare_ctrl();
         idle = (good_rd || ctrl_rd) ? 0 : idle + 1;
         if (idle > WAIT_LIMIT)
            report_timeout("output words");
         step();
      end
      good_rd = 1'b0;
      ctrl_rd = 1'b0;
   endtask

   task automatic expect_outputs_empty();
      checks++;
      assert (good_empty && ctrl_empty)
      else
      begin
         errors++;
         $display("Fail at %0t: output fifos hold extra words", $time);
      end
   endtask

   task automatic wait_for_full();
      int waited;
      waited = 0;
      while (!rx_full && waited < WAIT_LIMIT && !timed_out)
      begin
         step();
         waited++;
      end
      checks++;
      assert (rx_full)
      else
      begin
         errors++;
         $display("Fail at %0t: rx_full never rose with outputs unread", $time);
      end
      // nothing read yet
      checks++;
      assert (!good_empty && !ctrl_empty)
      else
      begin
         errors++;
         $display("Fail at %0t: outputs empty while the source is held", $time);
      end
   endtask

   task automatic verify_reset_values();
      checks++;
      assert (good_empty && ctrl_empty && !rx_full
              && !u_s2mm_rx_top.good_wren && !u_s2mm_rx_top.ctrl_wren
              && !u_s2mm_rx_top.info_wren && !u_s2mm_rx_top.data_rden
              && !u_s2mm_rx_top.info_rden)
      else
      begin
         errors++;
         $display("Fail at %0t: wrong levels after reset", $time);
      end
   endtask

   task automatic single_good_frame();
      sending_done = 1'b0;
      send_frame(4, 8, 1'b0, 1'b0);
      sending_done = 1'b1;
      drain_outputs();
      expect_outputs_empty();
   endtask

   // dropped frame leaves nothing ahead of the good one
   task automatic dropped_then_good();
      sending_done = 1'b0;
      send_frame(3, 8, 1'b1, 1'b0);
      send_frame(2, 8, 1'b0, 1'b1);
      sending_done = 1'b1;
      drain_outputs();
      expect_outputs_empty();
   endtask

   task automatic partial_keep_and_tag();
      sending_done = 1'b0;
      send_frame(3, 5, 1'b0, 1'b1);
      send_frame(2, 3, 1'b0, 1'b0);
      sending_done = 1'b1;
      drain_outputs();
      expect_outputs_empty();
   endtask

   // outputs unread until rx_full holds the source
   task automatic backpressure_hold();
      sending_done = 1'b0;
      fork
         begin
            for (int f = 0; f < 10; f++)
               send_frame(8, 8, 1'b0, f[0]);
            sending_done = 1'b1;
         end
         begin
            wait_for_full();
            drain_outputs();
         end
      join
      expect_outputs_empty();
   endtask

   task automatic random_back_to_back();
      int r;
      sending_done = 1'b0;
      last_seen    = 0;
      good_frames  = 0;
      fork
         begin
            for (int f = 0; f < 20; f++)
            begin
               r = $random(seed);
               send_frame(1 + (r & 7), 1 + ((r >> 3) & 7), ((r >> 6) & 3) == 0, r[9]);
            end
            sending_done = 1'b1;
         end
         drain_outputs();
      join
      expect_outputs_empty();
      checks++;
      assert (last_seen == good_frames)
      else
      begin
         errors++;
         $display("Fail at %0t: %0d last words for %0d good frames", $time,
                  last_seen, good_frames);
      end
   endtask

   initial
   begin
      seed         = 73;
      errors       = 0;
      checks       = 0;
      last_seen    = 0;
      good_frames  = 0;
      sending_done = 1'b0;
      timed_out    = 1'b0;
      rx_valid     = 1'b0;
      rx_data      = '0;
      rx_keep      = '0;
      rx_last      = 1'b0;
      rx_bad       = 1'b0;
      rx_tag       = 1'b0;
      good_rd      = 1'b0;
      ctrl_rd      = 1'b0;
      sys_rst      = 1'b1;
      repeat (4) @(posedge s2mm_clk);
      #DRIVE_DELAY;
      sys_rst = 1'b0;
      verify_reset_values();
      single_good_frame();
      if (!timed_out)
         dropped_then_good();
      if (!timed_out)
         partial_keep_and_tag();
      if (!timed_out)
         backpressure_hold();
      if (!timed_out)
         random_back_to_back();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

//--- s2mm_rx_top.f
+incdir+.
s2mm_frame_pkg.sv
s2mm_ctrl_pkg.sv
sync_fifo.sv
rx_ingress.sv
ifm_out_fsm.sv
s2mm_rx_top.sv
s2mm_rx_sva.sv
s2mm_rx_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the s2mm receive testbench with verilator, run it, check the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
   --top-module s2mm_rx_tb -f s2mm_rx_top.f
./obj_dir/Vs2mm_rx_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "TESTBENCH PASSED" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
